/* source/pipe_pkg.sv */
package pipe_pkg;

    // datapath widths
    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;

    // alu op codes
    localparam int ALU_OP_W = 3;
    localparam logic [ALU_OP_W-1:0] OP_ADD = 3'd0;
    localparam logic [ALU_OP_W-1:0] OP_SUB = 3'd1;
    localparam logic [ALU_OP_W-1:0] OP_AND = 3'd2;
    localparam logic [ALU_OP_W-1:0] OP_OR  = 3'd3;
    localparam logic [ALU_OP_W-1:0] OP_XOR = 3'd4;
    localparam logic [ALU_OP_W-1:0] OP_SLL = 3'd5;
    localparam logic [ALU_OP_W-1:0] OP_SRL = 3'd6;
    localparam logic [ALU_OP_W-1:0] OP_SLT = 3'd7;

    // writeback source, upper bit set means load
    localparam int WB_SEL_W = 2;
    localparam logic [WB_SEL_W-1:0] WB_ALU  = 2'b00;
    localparam logic [WB_SEL_W-1:0] WB_PC4  = 2'b01;
    localparam logic [WB_SEL_W-1:0] WB_LOAD = 2'b10;

    // memory access size
    localparam int SIZE_W = 2;
    localparam logic [SIZE_W-1:0] SIZE_B   = 2'd0;
    localparam logic [SIZE_W-1:0] SIZE_H   = 2'd1;
    localparam logic [SIZE_W-1:0] SIZE_W32 = 2'd2;
    localparam logic [SIZE_W-1:0] SIZE_D   = 2'd3;

endpackage

/* source/mem_pkg.sv */
package mem_pkg;

    // depth in 64-bit words
    localparam int MEM_WORDS = 256;

    // byte address bits decoded by the memory
    localparam int MEM_ADDR_W = 11;

    // one strobe per byte lane
    localparam int STRB_W = 8;

    // request to response, in cycles
    localparam int MEM_RD_LATENCY = 2;

endpackage

/* source/exec_alu.sv */
`timescale 1ns/1ps

module exec_alu (
    input  logic [pipe_pkg::ALU_OP_W-1:0] alu_op,
    input  logic [pipe_pkg::XLEN-1:0]     src1,
    input  logic [pipe_pkg::XLEN-1:0]     src2,
    output logic [pipe_pkg::XLEN-1:0]     alu_out
);

    logic [5:0] shamt;
    logic       less;

    // rv64 shifts only look at six bits
    assign shamt = src2[5:0];

    assign less = $signed(src1) < $signed(src2);

    always_comb begin
        case (alu_op)
            pipe_pkg::OP_ADD: begin
                alu_out = src1 + src2;
            end
            pipe_pkg::OP_SUB: begin
                alu_out = src1 - src2;
            end
            pipe_pkg::OP_AND: begin
                alu_out = src1 & src2;
            end
            pipe_pkg::OP_OR: begin
                alu_out = src1 | src2;
            end
            pipe_pkg::OP_XOR: begin
                alu_out = src1 ^ src2;
            end
            pipe_pkg::OP_SLL: begin
                alu_out = src1 << shamt;
            end
            pipe_pkg::OP_SRL: begin
                // logical, zero fill from the top
                alu_out = src1 >> shamt;
            end
            pipe_pkg::OP_SLT: begin
                alu_out = {{(pipe_pkg::XLEN-1){1'b0}}, less};
            end
            default: begin
                alu_out = src1 + src2;
            end
        endcase
    end

endmodule

/* source/addr_gen.sv */
`timescale 1ns/1ps

module addr_gen (
    input  logic [pipe_pkg::XLEN-1:0]   src1,
    input  logic [pipe_pkg::XLEN-1:0]   src2,
    input  logic [pipe_pkg::XLEN-1:0]   imm,
    input  logic [pipe_pkg::SIZE_W-1:0] mem_size,
    output logic [pipe_pkg::XLEN-1:0]   mem_addr,
    output logic [mem_pkg::STRB_W-1:0]  wstrb,
    output logic [pipe_pkg::XLEN-1:0]   wdata
);

    logic [$clog2(mem_pkg::STRB_W)-1:0] byte_off;
    logic [mem_pkg::STRB_W-1:0]         base_strb;

    // base plus offset, as for any rv load or store
    assign mem_addr = src1 + imm;
    assign byte_off = mem_addr[$clog2(mem_pkg::STRB_W)-1:0];

    // lanes covered by the access, before the lane shift
    always_comb begin
        case (mem_size)
            pipe_pkg::SIZE_B: begin
                base_strb = 8'h01;
            end
            pipe_pkg::SIZE_H: begin
                base_strb = 8'h03;
            end
            pipe_pkg::SIZE_W32: begin
                base_strb = 8'h0f;
            end
            default: begin
                base_strb = 8'hff;
            end
        endcase
    end

    // assumes natural alignment, so nothing spills past lane 7
    assign wstrb = base_strb << byte_off;

    // store data moved up to the addressed lane
    assign wdata = src2 << {byte_off, 3'b000};

endmodule

/* source/ex_mem_reg.sv */
`timescale 1ns/1ps

module ex_mem_reg (
    input  logic                                 I_sys_clk,
    input  logic                                 I_rst,
    input  logic                                 in_valid,
    output logic                                 allowin,
    input  logic [pipe_pkg::XLEN-1:0]            alu_in,
    input  logic [pipe_pkg::XLEN-1:0]            addr_in,
    input  logic [pipe_pkg::XLEN-1:0]            wdata_in,
    input  logic [pipe_pkg::XLEN-1:0]            pc_in,
    input  logic [mem_pkg::STRB_W-1:0]           wstrb_in,
    input  logic [pipe_pkg::SIZE_W-1:0]          size_in,
    input  logic                                 unsigned_in,
    input  logic [pipe_pkg::WB_SEL_W-1:0]        wb_sel_in,
    input  logic [pipe_pkg::REG_ADDR_W-1:0]      rd_addr_in,
    input  logic                                 reg_wen_in,
    input  logic                                 mem_wen_in,
    output logic                                 wb_valid,
    input  logic                                 wb_ready,
    output logic [pipe_pkg::XLEN-1:0]            alu_out,
    output logic [pipe_pkg::XLEN-1:0]            pc_out,
    output logic [pipe_pkg::XLEN-1:0]            mem_addr,
    output logic [pipe_pkg::XLEN-1:0]            wdata,
    output logic [mem_pkg::STRB_W-1:0]           wstrb,
    output logic [pipe_pkg::SIZE_W-1:0]          mem_size,
    output logic                                 mem_unsigned,
    output logic [pipe_pkg::WB_SEL_W-1:0]        wb_sel,
    output logic [pipe_pkg::REG_ADDR_W-1:0]      rd_addr,
    output logic                                 reg_wen,
    output logic                                 mem_rd_en,
    output logic                                 mem_wen,
    input  logic                                 rdata_valid,
    output logic                                 rsp_take
);

    logic entry_valid;
    logic load_wait;
    logic is_store;
    logic accept;
    logic retire;

    // a load is held back until load_wait clears
    assign wb_valid = entry_valid && !load_wait;
    assign retire   = wb_valid && wb_ready;
    assign allowin  = !entry_valid || retire;
    assign accept   = in_valid && allowin;

    // memory side effects happen when the entry leaves
    assign mem_wen  = retire && is_store;
    assign rsp_take = retire && wb_sel[1];

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            entry_valid <= 1'b0;
            load_wait   <= 1'b0;
            mem_rd_en   <= 1'b0;
        end else begin
            // read request fires the cycle after a load is taken
            mem_rd_en <= accept && wb_sel_in[1];
            if (allowin) begin
                entry_valid <= in_valid;
            end
            if (accept) begin
                load_wait <= wb_sel_in[1];
            end else if (rdata_valid) begin
                load_wait <= 1'b0;
            end
        end
    end

    // entry payload
    always_ff @(posedge I_sys_clk) begin
        if (accept) begin
            alu_out      <= alu_in;
            pc_out       <= pc_in;
            mem_addr     <= addr_in;
            wdata        <= wdata_in;
            wstrb        <= wstrb_in;
            mem_size     <= size_in;
            mem_unsigned <= unsigned_in;
            wb_sel       <= wb_sel_in;
            rd_addr      <= rd_addr_in;
            reg_wen      <= reg_wen_in;
            is_store     <= mem_wen_in;
        end
    end

    a_rd_wr_excl: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        !(mem_rd_en && mem_wen));

    // a stalled writeback keeps its entry and its response
    a_wb_hold: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        wb_valid && !wb_ready |=> wb_valid && entry_valid);

endmodule

/* source/data_mem.sv */
`timescale 1ns/1ps

module data_mem (
    input  logic                          I_sys_clk,
    input  logic                          I_rst,
    input  logic                          mem_rd_en,
    input  logic                          mem_wen,
    input  logic [pipe_pkg::XLEN-1:0]     mem_addr,
    input  logic [mem_pkg::STRB_W-1:0]    wstrb,
    input  logic [pipe_pkg::XLEN-1:0]     wdata,
    output logic [pipe_pkg::XLEN-1:0]     rdata,
    output logic                          rdata_valid,
    input  logic                          rsp_take
);

    logic [pipe_pkg::XLEN-1:0] mem [mem_pkg::MEM_WORDS];

    logic [mem_pkg::MEM_ADDR_W-$clog2(mem_pkg::STRB_W)-1:0] word_idx;
    logic [mem_pkg::MEM_RD_LATENCY-1:0]                     pend;
    logic                                                   held;
    logic [pipe_pkg::XLEN-1:0]                              rd_word;

    // drop the byte offset, upper address bits are ignored
    assign word_idx = mem_addr[mem_pkg::MEM_ADDR_W-1:$clog2(mem_pkg::STRB_W)];

    always_ff @(posedge I_sys_clk) begin
        if (mem_wen) begin
            for (int b = 0; b < mem_pkg::STRB_W; b++) begin
                if (wstrb[b]) begin
                    mem[word_idx][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
        // word sampled at request time, only one read is ever in flight
        if (mem_rd_en) begin
            rd_word <= mem[word_idx];
        end
    end

    // latency line for the pending read
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            pend <= '0;
            held <= 1'b0;
        end else begin
            pend <= {pend[mem_pkg::MEM_RD_LATENCY-2:0], mem_rd_en};
            held <= (pend[mem_pkg::MEM_RD_LATENCY-1] || held) && !rsp_take;
        end
    end

    // response stays up until the pipeline takes it
    assign rdata_valid = pend[mem_pkg::MEM_RD_LATENCY-1] || held;
    assign rdata       = rd_word;

    a_one_read: assert property (@(posedge I_sys_clk) disable iff (I_rst)
        mem_rd_en |-> !(|pend) && !held);

endmodule

/* source/wb_select.sv */
`timescale 1ns/1ps

module wb_select (
    input  logic [pipe_pkg::WB_SEL_W-1:0]          wb_sel,
    input  logic [pipe_pkg::XLEN-1:0]              alu_out,
    input  logic [pipe_pkg::XLEN-1:0]              pc_out,
    input  logic [pipe_pkg::XLEN-1:0]              rdata,
    input  logic [$clog2(mem_pkg::STRB_W)-1:0]     addr_lo,
    input  logic [pipe_pkg::SIZE_W-1:0]            mem_size,
    input  logic                                   mem_unsigned,
    output logic [pipe_pkg::XLEN-1:0]              wb_data
);

    logic [pipe_pkg::XLEN-1:0] lane;
    logic [pipe_pkg::XLEN-1:0] load_data;

    // addressed lane down to bit 0
    assign lane = rdata >> {addr_lo, 3'b000};

    always_comb begin
        case (mem_size)
            pipe_pkg::SIZE_B: begin
                load_data = mem_unsigned ? {56'b0, lane[7:0]}
                                         : {{56{lane[7]}}, lane[7:0]};
            end
            pipe_pkg::SIZE_H: begin
                load_data = mem_unsigned ? {48'b0, lane[15:0]}
                                         : {{48{lane[15]}}, lane[15:0]};
            end
            pipe_pkg::SIZE_W32: begin
                load_data = mem_unsigned ? {32'b0, lane[31:0]}
                                         : {{32{lane[31]}}, lane[31:0]};
            end
            default: begin
                load_data = lane;
            end
        endcase
    end

    always_comb begin
        case (wb_sel)
            pipe_pkg::WB_LOAD: wb_data = load_data;
            pipe_pkg::WB_PC4:  wb_data = pc_out + 64'd4;
            default:           wb_data = alu_out;
        endcase
    end

endmodule

/* source/ex_mem_top.sv */
`timescale 1ns/1ps

module ex_mem_top (
    input  logic                              I_sys_clk,
    input  logic                              I_rst,
    input  logic                              in_valid,
    output logic                              allowin,
    input  logic [pipe_pkg::ALU_OP_W-1:0]     alu_op,
    input  logic [pipe_pkg::XLEN-1:0]         src1,
    input  logic [pipe_pkg::XLEN-1:0]         src2,
    input  logic [pipe_pkg::XLEN-1:0]         imm,
    input  logic [pipe_pkg::XLEN-1:0]         pc,
    input  logic [pipe_pkg::WB_SEL_W-1:0]     wb_sel_in,
    input  logic [pipe_pkg::REG_ADDR_W-1:0]   rd_addr_in,
    input  logic                              reg_wen_in,
    input  logic                              mem_wen_in,
    input  logic [pipe_pkg::SIZE_W-1:0]       size_in,
    input  logic                              unsigned_in,
    output logic                              wb_valid,
    input  logic                              wb_ready,
    output logic [pipe_pkg::XLEN-1:0]         wb_data,
    output logic [pipe_pkg::REG_ADDR_W-1:0]   wb_rd_addr,
    output logic                              wb_reg_wen,
    output logic [pipe_pkg::XLEN-1:0]         wb_pc
);

    // execute stage results
    logic [pipe_pkg::XLEN-1:0]       ex_alu;
    logic [pipe_pkg::XLEN-1:0]       ex_addr;
    logic [pipe_pkg::XLEN-1:0]       ex_wdata;
    logic [mem_pkg::STRB_W-1:0]      ex_wstrb;

    // registered entry
    logic [pipe_pkg::XLEN-1:0]       mm_alu;
    logic [pipe_pkg::XLEN-1:0]       mm_addr;
    logic [pipe_pkg::XLEN-1:0]       mm_wdata;
    logic [mem_pkg::STRB_W-1:0]      mm_wstrb;
    logic [pipe_pkg::SIZE_W-1:0]     mm_size;
    logic                            mm_unsigned;
    logic [pipe_pkg::WB_SEL_W-1:0]   mm_wb_sel;

    // memory side
    logic                            mem_rd_en;
    logic                            mem_wen;
    logic [pipe_pkg::XLEN-1:0]       rdata;
    logic                            rdata_valid;
    logic                            rsp_take;

    exec_alu exec_alu_inst (
        .alu_op  (alu_op),
        .src1    (src1),
        .src2    (src2),
        .alu_out (ex_alu)
    );

    addr_gen addr_gen_inst (
        .src1     (src1),
        .src2     (src2),
        .imm      (imm),
        .mem_size (size_in),
        .mem_addr (ex_addr),
        .wstrb    (ex_wstrb),
        .wdata    (ex_wdata)
    );

    ex_mem_reg ex_mem_reg_inst (
        .I_sys_clk    (I_sys_clk),
        .I_rst        (I_rst),
        .in_valid     (in_valid),
        .allowin      (allowin),
        .alu_in       (ex_alu),
        .addr_in      (ex_addr),
        .wdata_in     (ex_wdata),
        .pc_in        (pc),
        .wstrb_in     (ex_wstrb),
        .size_in      (size_in),
        .unsigned_in  (unsigned_in),
        .wb_sel_in    (wb_sel_in),
        .rd_addr_in   (rd_addr_in),
        .reg_wen_in   (reg_wen_in),
        .mem_wen_in   (mem_wen_in),
        .wb_valid     (wb_valid),
        .wb_ready     (wb_ready),
        .alu_out      (mm_alu),
        .pc_out       (wb_pc),
        .mem_addr     (mm_addr),
        .wdata        (mm_wdata),
        .wstrb        (mm_wstrb),
        .mem_size     (mm_size),
        .mem_unsigned (mm_unsigned),
        .wb_sel       (mm_wb_sel),
        .rd_addr      (wb_rd_addr),
        .reg_wen      (wb_reg_wen),
        .mem_rd_en    (mem_rd_en),
        .mem_wen      (mem_wen),
        .rdata_valid  (rdata_valid),
        .rsp_take     (rsp_take)
    );

    data_mem data_mem_inst (
        .I_sys_clk   (I_sys_clk),
        .I_rst       (I_rst),
        .mem_rd_en   (mem_rd_en),
        .mem_wen     (mem_wen),
        .mem_addr    (mm_addr),
        .wstrb       (mm_wstrb),
        .wdata       (mm_wdata),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .rsp_take    (rsp_take)
    );

    wb_select wb_select_inst (
        .wb_sel       (mm_wb_sel),
        .alu_out      (mm_alu),
        .pc_out       (wb_pc),
        .rdata        (rdata),
        .addr_lo      (mm_addr[$clog2(mem_pkg::STRB_W)-1:0]),
        .mem_size     (mm_size),
        .mem_unsigned (mm_unsigned),
        .wb_data      (wb_data)
    );

endmodule

/* testbench/ex_mem_tb.sv */
`timescale 1ns/1ps

module ex_mem_tb;

    localparam int CLK_PERIOD      = 10;
    localparam int SAMPLE_DELAY    = 4;
    localparam int RESET_CYCLES    = 3;
    localparam int MAX_TESTS       = 64;
    localparam int CYCLES_PER_TEST = 20;
    localparam logic [15:0] LFSR_SEED = 16'd48;

    logic                            I_sys_clk;
    logic                            I_rst;
    logic                            in_valid;
    logic                            allowin;
    logic [pipe_pkg::ALU_OP_W-1:0]   alu_op;
    logic [pipe_pkg::XLEN-1:0]       src1;
    logic [pipe_pkg::XLEN-1:0]       src2;
    logic [pipe_pkg::XLEN-1:0]       imm;
    logic [pipe_pkg::XLEN-1:0]       pc;
    logic [pipe_pkg::WB_SEL_W-1:0]   wb_sel_in;
    logic [pipe_pkg::REG_ADDR_W-1:0] rd_addr_in;
    logic                            reg_wen_in;
    logic                            mem_wen_in;
    logic [pipe_pkg::SIZE_W-1:0]     size_in;
    logic                            unsigned_in;
    logic                            wb_valid;
    logic                            wb_ready;
    logic [pipe_pkg::XLEN-1:0]       wb_data;
    logic [pipe_pkg::REG_ADDR_W-1:0] wb_rd_addr;
    logic                            wb_reg_wen;
    logic [pipe_pkg::XLEN-1:0]       wb_pc;

    // op sel size unsigned mem_wen reg_wen rd src1 src2 imm pc expected
    logic [63:0] rows [MAX_TESTS][12];
    int          expect_q [$];
    int          num_tests = 0;
    int          next_row = 0;
    int          retired = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          other_errors = 0;
    logic        test_ok;
    logic        tests_loaded = 1'b0;
    logic [15:0] lfsr;

    ex_mem_top ex_mem_top_inst (.*);

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        // galois form, taps 16 14 13 11
        return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
    endfunction

    task automatic read_tests();
        int    fd;
        string line;
        fd = $fopen("testbench/ex_mem_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/ex_mem_tests.txt");
            other_errors++;
        end else begin
            while ($fgets(line, fd) != 0 && num_tests < MAX_TESTS) begin
                // comment lines give no fields and are skipped
                if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                        rows[num_tests][0], rows[num_tests][1], rows[num_tests][2],
                        rows[num_tests][3], rows[num_tests][4], rows[num_tests][5],
                        rows[num_tests][6], rows[num_tests][7], rows[num_tests][8],
                        rows[num_tests][9], rows[num_tests][10],
                        rows[num_tests][11]) == 12) begin
                    num_tests++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_row(input int idx);
        in_valid    = 1'b1;
        alu_op      = rows[idx][0][pipe_pkg::ALU_OP_W-1:0];
        wb_sel_in   = rows[idx][1][pipe_pkg::WB_SEL_W-1:0];
        size_in     = rows[idx][2][pipe_pkg::SIZE_W-1:0];
        unsigned_in = rows[idx][3][0];
        mem_wen_in  = rows[idx][4][0];
        reg_wen_in  = rows[idx][5][0];
        rd_addr_in  = rows[idx][6][pipe_pkg::REG_ADDR_W-1:0];
        src1        = rows[idx][7];
        src2        = rows[idx][8];
        imm         = rows[idx][9];
        pc          = rows[idx][10];
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got %h, expected %h", name, actual, expected);
            test_ok = 1'b0;
        end
    endtask

    task automatic count_result(input string name);
        if (test_ok) begin
            pass_count++;
            $display("%s passed", name);
        end else begin
            fail_count++;
            $display("%s failed", name);
        end
    endtask

    task automatic check_retire();
        int idx;
        if (expect_q.size() == 0) begin
            $display("a writeback retired with no instruction outstanding");
            other_errors++;
        end else begin
            idx = expect_q.pop_front();
            test_ok = 1'b1;
            check_value("wb_data", wb_data, rows[idx][11]);
            check_value("wb_rd_addr", 64'(wb_rd_addr), rows[idx][6]);
            check_value("wb_reg_wen", 64'(wb_reg_wen), rows[idx][5]);
            check_value("wb_pc", wb_pc, rows[idx][10]);
            count_result($sformatf("test %0d", idx));
            retired++;
        end
    endtask

    initial begin
        I_sys_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) I_sys_clk = ~I_sys_clk;
        end
    end

    initial begin
        wait (tests_loaded);
        repeat ((num_tests + 1) * CYCLES_PER_TEST + RESET_CYCLES) @(posedge I_sys_clk);
        $display("run timed out, %0d of %0d tests retired", retired, num_tests);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        I_rst       = 1'b1;
        in_valid    = 1'b0;
        alu_op      = '0;
        src1        = '0;
        src2        = '0;
        imm         = '0;
        pc          = '0;
        wb_sel_in   = '0;
        rd_addr_in  = '0;
        reg_wen_in  = 1'b0;
        mem_wen_in  = 1'b0;
        size_in     = '0;
        unsigned_in = 1'b0;
        wb_ready    = 1'b0;
        lfsr        = LFSR_SEED;
        read_tests();
        tests_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge I_sys_clk);
        @(negedge I_sys_clk);
        I_rst = 1'b0;
        #SAMPLE_DELAY;
        // idle right after reset
        test_ok = 1'b1;
        check_value("allowin", 64'(allowin), 64'd1);
        check_value("wb_valid", 64'(wb_valid), 64'd0);
        count_result("reset");
        while (retired < num_tests) begin
            @(negedge I_sys_clk);
            lfsr     = lfsr_step(lfsr);
            wb_ready = lfsr[0];
            if (next_row < num_tests) begin
                drive_row(next_row);
            end else begin
                in_valid = 1'b0;
            end
            // one ns before the rising edge, all handshakes have settled
            #SAMPLE_DELAY;
            if (in_valid && allowin) begin
                expect_q.push_back(next_row);
                next_row++;
            end
            if (wb_valid && wb_ready) begin
                check_retire();
            end
        end
        if (num_tests == 0) begin
            $display("no tests were read from the test file");
        end
        $display("passed %0d, failed %0d, other errors %0d",
                 pass_count, fail_count, other_errors);
        if (num_tests > 0 && fail_count == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* testbench/ex_mem_tests.txt */
# op sel size uns mem_wen reg_wen rd src1 src2 imm pc expected_wb_data, all hex
# sel 0 alu, 1 pc+4, 2 load; size 0 byte, 1 half, 2 word, 3 doubleword
0 0 0 0 0 1 01 10 22 0 200 32
1 0 0 0 0 1 02 5 7 0 204 fffffffffffffffe
2 0 0 0 0 1 03 ff00ff00 0ff00ff0 0 208 f000f00
3 0 0 0 0 1 04 f0 0f 0 20c ff
4 0 0 0 0 1 05 aaaa ffff 0 210 5555
5 0 0 0 0 1 06 1 43 0 214 8
6 0 0 0 0 1 07 8000000000000000 3f 0 218 1
7 0 0 0 0 1 08 ffffffffffffffff 1 0 21c 1
0 1 0 0 0 1 0a 0 0 0 1000 1004
0 1 0 0 0 1 0b 3 4 0 2468 246c
0 0 3 0 1 0 00 100 1122334455667788 0 300 1122334455667888
0 0 0 0 1 0 00 100 9a 3 304 19a
0 0 3 0 1 0 00 108 0 0 308 108
0 0 1 0 1 0 00 108 8001 2 30c 8109
0 0 2 0 1 0 00 110 deadbeef 4 310 deadbfff
0 2 3 0 0 1 0b 100 0 0 400 112233449a667788
0 2 0 0 0 1 0c 100 0 3 404 ffffffffffffff9a
0 2 0 1 0 1 0d 100 0 3 408 9a
0 2 1 0 0 1 0f 108 0 2 410 ffffffffffff8001
0 2 1 1 0 1 10 108 0 2 414 8001
0 2 2 0 0 1 11 110 0 4 418 ffffffffdeadbeef
0 2 2 1 0 1 12 110 0 4 41c deadbeef
0 2 2 0 0 1 13 100 0 0 420 ffffffff9a667788
0 2 3 0 0 1 14 108 0 0 424 80010000
0 2 1 0 0 1 15 100 0 6 428 1122
4 0 0 0 0 0 16 1234 1234 0 42c 0
0 0 0 0 1 0 00 100 5a 0 430 15a
0 2 3 0 0 1 17 100 0 0 434 112233449a66775a

/* project.f */
source/pipe_pkg.sv
source/mem_pkg.sv
source/exec_alu.sv
source/addr_gen.sv
source/ex_mem_reg.sv
source/data_mem.sv
source/wb_select.sv
source/ex_mem_top.sv
testbench/ex_mem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module ex_mem_tb -o ex_mem_sim

output=$(./obj_dir/ex_mem_sim)
echo "$output"

if echo "$output" | grep -Fqx "** PASS **"; then
    exit 0
fi
exit 1
